// File: bench/frontend_model.sv
`timescale 1ns/10ps

module frontend_model #(
  parameter int num_lines = 32
) (
  input  logic                               clock,
  input  logic                               arst_n,
  input  frontend_pkg::bus_command_t         proc2mem_command,
  input  logic [frontend_pkg::xlen-1:0]      proc2mem_addr,
  output logic [frontend_pkg::mem_tag_w-1:0] mem2proc_response,
  output logic [frontend_pkg::xlen-1:0]      mem2proc_data,
  output logic [frontend_pkg::mem_tag_w-1:0] mem2proc_tag,
  output logic                               addr_resident,
  input  logic                               plant_en,
  input  logic [11:0]                        plant_pc,
  input  logic [5:0]                         plant_op,
  input  logic [frontend_pkg::xlen-1:0]      check_pc,
  output logic [frontend_pkg::inst_w-1:0]    exp_ir,
  output frontend_pkg::inst_class_t          exp_class
);

  localparam int idx_w = $clog2(num_lines);

  logic [31:0]          image [1024];  // 4 KiB, wraps above
  logic [12:0]          res_line [num_lines];
  logic [num_lines-1:0] res_valid;
  logic [3:0]           next_tag;
  logic [3:0]           pend_tag;
  logic [63:0]          pend_addr;
  int                   pend_cnt;

  // Any of the 24 alu, load, store or branch opcodes
  function automatic logic [31:0] random_word();
    int k;
    k = int'($urandom % 24);
    return {(k < 4) ? 6'(6'h10 + k) : (k < 6) ? 6'(6'h28 + k - 4) :
            (k < 8) ? 6'(6'h2c + k - 6) : 6'(6'h30 + k - 8), 26'($urandom)};
  endfunction

  function automatic frontend_pkg::inst_class_t class_rule(input logic [5:0] op);
    if (op == 6'h00) return frontend_pkg::cls_halt;
    if (op >= 6'h10 && op <= 6'h13) return frontend_pkg::cls_alu;
    if (op[5:1] == 5'b10100) return frontend_pkg::cls_load;   // 0x28, 0x29
    if (op[5:1] == 5'b10110) return frontend_pkg::cls_store;  // 0x2c, 0x2d
    if (op[5:4] == 2'b11) return frontend_pkg::cls_branch;
    return frontend_pkg::cls_illegal;
  endfunction

  assign exp_ir        = image[check_pc[11:2]];
  assign exp_class     = class_rule(exp_ir[31:26]);
  assign addr_resident = res_valid[proc2mem_addr[3 +: idx_w]] &&
                         (res_line[proc2mem_addr[3 +: idx_w]] == proc2mem_addr[15:3]);

  // New image on every reset
  always @(posedge clock) begin
    if (!arst_n) begin
      for (int i = 0; i < 1024; i++) image[i] = random_word();
      if (plant_en) image[plant_pc[11:2]] = {plant_op, 26'($urandom)};
    end
  end

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mem2proc_response <= '0;
      mem2proc_data     <= '0;
      mem2proc_tag      <= '0;
      res_valid         <= '0;
      next_tag          <= 4'd1;
      pend_cnt          <= 0;
    end else begin
      mem2proc_response <= '0;
      mem2proc_tag      <= '0;
      // A nonzero response already on the bus is being taken this edge
      if (proc2mem_command == frontend_pkg::bus_load && mem2proc_response == '0 &&
          $urandom % 2 == 0) begin
        mem2proc_response <= next_tag;
        pend_tag          <= next_tag;
        pend_addr         <= proc2mem_addr;
        pend_cnt          <= 1 + int'($urandom % 6);
        next_tag          <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end else if (pend_cnt != 0) begin
        pend_cnt <= pend_cnt - 1;
        if (pend_cnt == 1) begin
          mem2proc_tag  <= pend_tag;
          mem2proc_data <= {image[{pend_addr[11:3], 1'b1}], image[{pend_addr[11:3], 1'b0}]};
          res_valid[pend_addr[3 +: idx_w]] <= 1'b1;
          res_line[pend_addr[3 +: idx_w]]  <= pend_addr[15:3];
        end
      end
    end
  end

endmodule

// File: bench/frontend_tb.sv
`timescale 1ns/10ps

module frontend_tb;

  localparam int n_stream     = 200;  // Dispatches per stream test
  localparam int quiet_cycles = 50;
  localparam int halt_pc      = 'h40;
  localparam int illegal_pc   = 'h9c;  // Upper half of its line
  localparam int loop_base    = 'h400;
  localparam int loop_end     = 'h460;
  localparam int cyc_per_inst = 40;    // Miss, refusals, slow data, stalls
  localparam int total_insts  = 4 * n_stream + halt_pc / 4 + illegal_pc / 4 + 2 +
                                2 * quiet_cycles;

  logic        clock;
  logic        arst_n;
  logic [3:0]  mem2proc_response;
  logic [63:0] mem2proc_data;
  logic [3:0]  mem2proc_tag;
  logic        dispatch_ready;
  logic        redirect_en;
  logic [63:0] redirect_pc;
  logic [63:0] proc2mem_addr;
  logic        dispatch_valid;
  logic [63:0] dispatch_pc;
  logic [31:0] dispatch_ir;
  frontend_pkg::bus_command_t proc2mem_command;
  frontend_pkg::inst_class_t  dispatch_class;
  frontend_pkg::inst_class_t  exp_class;
  frontend_pkg::error_code_t  error_status;
  logic        plant_en;
  logic [11:0] plant_pc;
  logic [5:0]  plant_op;
  logic        addr_resident;
  logic [63:0] exp_pc;
  logic [31:0] exp_ir;
  logic        prev_ready;
  logic        redir_pend;
  logic [63:0] redir_target;
  int          errors;
  int          err_mark;
  int          dispatched;
  int          tests_run;
  int          tests_failed;

  frontend #(.num_lines(32), .fb_depth(8)) frontend_inst (.*);

  frontend_model #(.num_lines(32)) frontend_model_inst (
    .clock, .arst_n, .proc2mem_command, .proc2mem_addr, .mem2proc_response,
    .mem2proc_data, .mem2proc_tag, .addr_resident, .plant_en, .plant_pc, .plant_op,
    .check_pc(exp_pc), .exp_ir, .exp_class
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    #(total_insts * cyc_per_inst * 4);
    $display("Watchdog expired, tests did not finish within %0d cycles",
             total_insts * cyc_per_inst);
    $display("Something failed");
    $finish;
  end

  task automatic apply_reset();
    @(posedge clock);
    arst_n         <= 1'b0;
    dispatch_ready <= 1'b0;
    redirect_en    <= 1'b0;
    repeat (2) @(posedge clock);
    assert (proc2mem_command == frontend_pkg::bus_none && !dispatch_valid &&
            error_status == frontend_pkg::no_error) else begin
      errors++;
      $display("Outputs not at their reset values during reset");
    end
    arst_n <= 1'b1;
    exp_pc     = '0;
    prev_ready = 1'b0;
    redir_pend = 1'b0;
    dispatched = 0;
    err_mark   = errors;
  endtask

  // Samples the values of the cycle that just ended
  task automatic check_dispatch();
    if (dispatch_valid) begin
      assert (prev_ready) else begin
        errors++;
        $display("Dispatch at PC %h after a cycle with dispatch_ready low", dispatch_pc);
      end
      assert (dispatch_pc == exp_pc) else begin
        errors++;
        $display("ERR dispatch_pc got %h expected %h", dispatch_pc, exp_pc);
      end
      assert (dispatch_ir == exp_ir) else begin
        errors++;
        $display("ERR dispatch_ir got %h expected %h", dispatch_ir, exp_ir);
      end
      assert (dispatch_class == exp_class) else begin
        errors++;
        $display("ERR dispatch_class got %h expected %h", dispatch_class, exp_class);
      end
      exp_pc = exp_pc + 64'd4;
      dispatched++;
    end
    assert (!(proc2mem_command == frontend_pkg::bus_load && addr_resident)) else begin
      errors++;
      $display("Load issued for line %h which is already in the cache", proc2mem_addr);
    end
    prev_ready = dispatch_ready;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("%s: passed, %0d dispatched", name, dispatched);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  // mode 0 sequential, 1 sparse random ready, 2 random redirects, 3 loop in a small region
  task automatic run_stream(input string name, input int mode);
    logic        ready;
    logic        redirect;
    logic [63:0] target;
    apply_reset();
    while (dispatched < n_stream) begin
      @(posedge clock);
      check_dispatch();
      if (redir_pend) begin
        exp_pc     = redir_target;  // Old stream ends with the sample above
        redir_pend = 1'b0;
      end
      // Ready slower than fetch so the buffer runs full
      ready    = (mode == 1) ? ($urandom % 8 == 0) : 1'b1;
      redirect = (mode == 2) && ($urandom % 16 == 0);
      target   = {52'd0, 10'($urandom), 2'b00};
      if (mode == 3) begin
        redirect = (exp_pc < 64'(loop_base)) || (exp_pc >= 64'(loop_end));
        target   = 64'(loop_base);
      end
      dispatch_ready <= ready;
      redirect_en    <= redirect;
      redirect_pc    <= target;
      if (redirect) begin
        redir_pend   = 1'b1;
        redir_target = target;
      end
    end
    finish_test(name);
  endtask

  task automatic run_stop(input string name, input logic [5:0] op, input int stop_pc,
                          input frontend_pkg::error_code_t code);
    @(posedge clock);
    plant_en <= 1'b1;
    plant_pc <= 12'(stop_pc);
    plant_op <= op;
    apply_reset();
    while (exp_pc <= 64'(stop_pc)) begin
      @(posedge clock);
      check_dispatch();
      dispatch_ready <= 1'b1;
    end
    assert (error_status == code) else begin
      errors++;
      $display("ERR error_status got %h expected %h", error_status, code);
    end
    repeat (quiet_cycles) begin
      @(posedge clock);
      assert (!dispatch_valid) else begin
        errors++;
        $display("Instruction at PC %h dispatched after the stop", dispatch_pc);
      end
    end
    plant_en <= 1'b0;
    finish_test(name);
  endtask

  initial begin
    void'($urandom(32'hfe77a0fa));
    arst_n         = 1'b0;
    dispatch_ready = 1'b0;
    redirect_en    = 1'b0;
    redirect_pc    = '0;
    plant_en       = 1'b0;
    plant_pc       = '0;
    plant_op       = '0;
    exp_pc         = '0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    run_stream("sequential", 0);
    run_stream("backpressure", 1);
    run_stream("redirect", 2);
    run_stream("cache_reuse", 3);
    run_stop("halt", 6'h00, halt_pc, frontend_pkg::halted_on_halt);
    run_stop("illegal", 6'h05, illegal_pc, frontend_pkg::halted_on_illegal);
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: hw/dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage (
  input  logic                            clock,
  input  logic                            arst_n,
  input  logic                            fb_empty,
  input  logic [frontend_pkg::xlen-1:0]   head_pc,
  input  logic [frontend_pkg::inst_w-1:0] head_ir,
  input  logic                            dispatch_ready,
  input  logic                            redirect_en,
  output logic                            pop,
  output logic                            dispatch_valid,
  output logic [frontend_pkg::xlen-1:0]   dispatch_pc,
  output logic [frontend_pkg::inst_w-1:0] dispatch_ir,
  output frontend_pkg::inst_class_t       dispatch_class,
  output frontend_pkg::error_code_t       error_status
);

  localparam int op_w = frontend_pkg::opcode_w;

  frontend_pkg::inst_class_t head_class;

  function automatic frontend_pkg::inst_class_t class_of(input logic [op_w-1:0] op);
    frontend_pkg::inst_class_t cls;
    case (op) inside
      6'h00:            cls = frontend_pkg::cls_halt;
      [6'h10:6'h13]:    cls = frontend_pkg::cls_alu;
      6'h28, 6'h29:     cls = frontend_pkg::cls_load;
      6'h2c, 6'h2d:     cls = frontend_pkg::cls_store;
      [6'h30:6'h3f]:    cls = frontend_pkg::cls_branch;
      default:          cls = frontend_pkg::cls_illegal;
    endcase
    return cls;
  endfunction

  assign head_class = class_of(head_ir[frontend_pkg::inst_w-1 -: op_w]);

  // A latched error stops everything until reset
  assign pop = !fb_empty && dispatch_ready && !redirect_en &&
               (error_status == frontend_pkg::no_error);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dispatch_valid <= 1'b0;
      error_status   <= frontend_pkg::no_error;
    end else begin
      dispatch_valid <= pop;
      if (pop && head_class == frontend_pkg::cls_halt) begin
        error_status <= frontend_pkg::halted_on_halt;
      end else if (pop && head_class == frontend_pkg::cls_illegal) begin
        error_status <= frontend_pkg::halted_on_illegal;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      dispatch_pc    <= head_pc;
      dispatch_ir    <= head_ir;
      dispatch_class <= head_class;
    end
  end

endmodule

// File: hw/fetch_buffer.sv
`timescale 1ns/10ps

module fetch_buffer #(
  parameter int fb_depth = 8,
  localparam int ptr_w = $clog2(fb_depth),
  localparam int cnt_w = ptr_w + 1
) (
  input  logic                            clock,
  input  logic                            arst_n,
  input  logic                            push,
  input  logic [frontend_pkg::xlen-1:0]   push_pc,
  input  logic [frontend_pkg::inst_w-1:0] push_ir,
  input  logic                            pop,
  input  logic                            flush,
  output logic                            fb_full,
  output logic                            fb_empty,
  output logic [frontend_pkg::xlen-1:0]   head_pc,
  output logic [frontend_pkg::inst_w-1:0] head_ir
);

  logic [frontend_pkg::xlen-1:0]   pc_q [fb_depth];
  logic [frontend_pkg::inst_w-1:0] ir_q [fb_depth];
  logic [ptr_w-1:0]                head;
  logic [ptr_w-1:0]                tail;
  logic [cnt_w-1:0]                count;

  assign fb_full  = (count == cnt_w'(fb_depth));
  assign fb_empty = (count == '0);
  assign head_pc  = pc_q[head];
  assign head_ir  = ir_q[head];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + 1'b1;  // Wraps, depth is a power of two
      if (pop) head <= head + 1'b1;
      count <= count + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      pc_q[tail] <= push_pc;
      ir_q[tail] <= push_ir;
    end
  end

  // Fetch must respect full
  a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
    push |-> !fb_full);

  // Dispatch must respect empty
  a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n)
    pop |-> !fb_empty);

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
  input  logic                            clock,
  input  logic                            arst_n,
  input  logic                            hit,
  input  logic [frontend_pkg::xlen-1:0]   hit_line,
  input  logic                            fb_full,
  input  logic                            redirect_en,
  input  logic [frontend_pkg::xlen-1:0]   redirect_pc,
  output logic [frontend_pkg::xlen-1:0]   fetch_pc,
  output logic                            push,
  output logic [frontend_pkg::xlen-1:0]   push_pc,
  output logic [frontend_pkg::inst_w-1:0] push_ir
);

  localparam int iw = frontend_pkg::inst_w;

  assign push    = hit && !fb_full && !redirect_en;
  assign push_pc = fetch_pc;
  // PC bit 2 picks the upper word of the line
  assign push_ir = fetch_pc[2] ? hit_line[2*iw-1:iw] : hit_line[iw-1:0];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc <= '0;
    end else if (redirect_en) begin
      fetch_pc <= redirect_pc;  // Wins over a hit
    end else if (push) begin
      fetch_pc <= fetch_pc + 'd4;
    end
  end

  // Redirect targets from the back end must keep the PC word aligned
  a_pc_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    fetch_pc[1:0] == 2'b00);

endmodule

// File: hw/frontend.sv
`timescale 1ns/10ps

module frontend #(
  parameter int num_lines = 32,
  parameter int fb_depth  = 8
) (
  input  logic                               clock,
  input  logic                               arst_n,
  input  logic [frontend_pkg::mem_tag_w-1:0] mem2proc_response,
  input  logic [frontend_pkg::xlen-1:0]      mem2proc_data,
  input  logic [frontend_pkg::mem_tag_w-1:0] mem2proc_tag,
  input  logic                               dispatch_ready,
  input  logic                               redirect_en,
  input  logic [frontend_pkg::xlen-1:0]      redirect_pc,
  output frontend_pkg::bus_command_t         proc2mem_command,
  output logic [frontend_pkg::xlen-1:0]      proc2mem_addr,
  output logic                               dispatch_valid,
  output logic [frontend_pkg::xlen-1:0]      dispatch_pc,
  output logic [frontend_pkg::inst_w-1:0]    dispatch_ir,
  output frontend_pkg::inst_class_t          dispatch_class,
  output frontend_pkg::error_code_t          error_status
);

  localparam int idx_w = $clog2(num_lines);
  localparam int tag_w = frontend_pkg::mem_addr_w - frontend_pkg::line_off_w - idx_w;

  // Cache array side
  logic [idx_w-1:0]                rd_idx;
  logic [tag_w-1:0]                rd_tag;
  logic                            wr_en;
  logic [idx_w-1:0]                wr_idx;
  logic [tag_w-1:0]                wr_tag;
  logic [frontend_pkg::xlen-1:0]   wr_data;
  logic [frontend_pkg::xlen-1:0]   line_data;
  logic                            line_valid;

  // Fetch side
  logic [frontend_pkg::xlen-1:0]   fetch_pc;
  logic                            hit;
  logic [frontend_pkg::xlen-1:0]   hit_line;
  logic                            push;
  logic [frontend_pkg::xlen-1:0]   push_pc;
  logic [frontend_pkg::inst_w-1:0] push_ir;

  // Buffer to dispatch
  logic                            fb_full;
  logic                            fb_empty;
  logic [frontend_pkg::xlen-1:0]   head_pc;
  logic [frontend_pkg::inst_w-1:0] head_ir;
  logic                            pop;

  icache_mem #(.num_lines(num_lines)) icache_mem_inst (
    .clock      (clock),
    .arst_n     (arst_n),
    .rd_idx     (rd_idx),
    .rd_tag     (rd_tag),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_tag     (wr_tag),
    .wr_data    (wr_data),
    .line_data  (line_data),
    .line_valid (line_valid)
  );

  icache_ctrl #(.num_lines(num_lines)) icache_ctrl_inst (
    .clock             (clock),
    .arst_n            (arst_n),
    .fetch_pc          (fetch_pc),
    .line_data         (line_data),
    .line_valid        (line_valid),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .rd_idx            (rd_idx),
    .rd_tag            (rd_tag),
    .wr_en             (wr_en),
    .wr_idx            (wr_idx),
    .wr_tag            (wr_tag),
    .wr_data           (wr_data),
    .hit               (hit),
    .hit_line          (hit_line),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr)
  );

  fetch_stage fetch_stage_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .hit         (hit),
    .hit_line    (hit_line),
    .fb_full     (fb_full),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .fetch_pc    (fetch_pc),
    .push        (push),
    .push_pc     (push_pc),
    .push_ir     (push_ir)
  );

  fetch_buffer #(.fb_depth(fb_depth)) fetch_buffer_inst (
    .clock    (clock),
    .arst_n   (arst_n),
    .push     (push),
    .push_pc  (push_pc),
    .push_ir  (push_ir),
    .pop      (pop),
    .flush    (redirect_en),  // Redirect empties the queue
    .fb_full  (fb_full),
    .fb_empty (fb_empty),
    .head_pc  (head_pc),
    .head_ir  (head_ir)
  );

  dispatch_stage dispatch_stage_inst (
    .clock          (clock),
    .arst_n         (arst_n),
    .fb_empty       (fb_empty),
    .head_pc        (head_pc),
    .head_ir        (head_ir),
    .dispatch_ready (dispatch_ready),
    .redirect_en    (redirect_en),
    .pop            (pop),
    .dispatch_valid (dispatch_valid),
    .dispatch_pc    (dispatch_pc),
    .dispatch_ir    (dispatch_ir),
    .dispatch_class (dispatch_class),
    .error_status   (error_status)
  );

endmodule

// File: hw/frontend_pkg.sv
package frontend_pkg;

  localparam int xlen       = 64;  // PC, bus data and cache line
  localparam int inst_w     = 32;
  localparam int mem_addr_w = 16;  // Implemented address space
  localparam int mem_tag_w  = 4;   // Zero means no value
  localparam int line_off_w = 3;   // Byte offset inside a 64-bit line
  localparam int opcode_w   = 6;   // Top bits of the instruction

  // Memory bus command
  typedef enum logic [1:0] {
    bus_none = 2'h0,
    bus_load = 2'h1
  } bus_command_t;

  // Dispatch class
  typedef enum logic [2:0] {
    cls_alu     = 3'h0,
    cls_load    = 3'h1,
    cls_store   = 3'h2,
    cls_branch  = 3'h3,
    cls_halt    = 3'h4,
    cls_illegal = 3'h5
  } inst_class_t;

  // Status, same codes as the full core
  typedef enum logic [1:0] {
    no_error          = 2'h0,
    halted_on_halt    = 2'h2,
    halted_on_illegal = 2'h3
  } error_code_t;

endpackage

// File: hw/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl #(
  parameter int num_lines = 32,
  localparam int idx_w = $clog2(num_lines),
  localparam int tag_w = frontend_pkg::mem_addr_w - frontend_pkg::line_off_w - idx_w
) (
  input  logic                               clock,
  input  logic                               arst_n,
  input  logic [frontend_pkg::xlen-1:0]      fetch_pc,
  input  logic [frontend_pkg::xlen-1:0]      line_data,
  input  logic                               line_valid,
  input  logic [frontend_pkg::mem_tag_w-1:0] mem2proc_response,
  input  logic [frontend_pkg::xlen-1:0]      mem2proc_data,
  input  logic [frontend_pkg::mem_tag_w-1:0] mem2proc_tag,
  output logic [idx_w-1:0]                   rd_idx,
  output logic [tag_w-1:0]                   rd_tag,
  output logic                               wr_en,
  output logic [idx_w-1:0]                   wr_idx,
  output logic [tag_w-1:0]                   wr_tag,
  output logic [frontend_pkg::xlen-1:0]      wr_data,
  output logic                               hit,
  output logic [frontend_pkg::xlen-1:0]      hit_line,
  output frontend_pkg::bus_command_t         proc2mem_command,
  output logic [frontend_pkg::xlen-1:0]      proc2mem_addr
);

  localparam int off_w = frontend_pkg::line_off_w;

  typedef enum logic [1:0] {
    ic_idle,
    ic_request,  // Command on the bus
    ic_wait      // Accepted, waiting for the tag
  } ic_state_t;

  ic_state_t                        state;
  logic [frontend_pkg::mem_tag_w-1:0] load_tag;
  logic                             miss;
  logic                             accepted;

  assign rd_idx   = fetch_pc[off_w +: idx_w];
  assign rd_tag   = fetch_pc[off_w+idx_w +: tag_w];
  assign hit      = line_valid;
  assign hit_line = line_data;

  assign miss     = (state == ic_idle) && !line_valid;
  assign accepted = (state == ic_request) && (mem2proc_response != '0);

  // Fill goes to the line named by the outstanding address
  assign wr_en   = (state == ic_wait) && (mem2proc_tag == load_tag);
  assign wr_idx  = proc2mem_addr[off_w +: idx_w];
  assign wr_tag  = proc2mem_addr[off_w+idx_w +: tag_w];
  assign wr_data = mem2proc_data;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state            <= ic_idle;
      proc2mem_command <= frontend_pkg::bus_none;
    end else begin
      case (state)
        ic_idle: if (miss) begin
          state            <= ic_request;
          proc2mem_command <= frontend_pkg::bus_load;
        end
        ic_request: if (accepted) begin
          state            <= ic_wait;
          proc2mem_command <= frontend_pkg::bus_none;
        end
        ic_wait: if (wr_en) state <= ic_idle;
        default: state <= ic_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (miss) proc2mem_addr <= {fetch_pc[frontend_pkg::xlen-1:off_w], {off_w{1'b0}}};
    if (accepted) load_tag <= mem2proc_response;
  end

  // Refused load stays on the bus unchanged
  a_addr_hold: assert property (@(posedge clock) disable iff (!arst_n)
    (proc2mem_command == frontend_pkg::bus_load && mem2proc_response == '0)
      |=> (proc2mem_command == frontend_pkg::bus_load && $stable(proc2mem_addr)));

endmodule

// File: hw/icache_mem.sv
`timescale 1ns/10ps

module icache_mem #(
  parameter int num_lines = 32,
  localparam int idx_w = $clog2(num_lines),
  localparam int tag_w = frontend_pkg::mem_addr_w - frontend_pkg::line_off_w - idx_w
) (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic [idx_w-1:0]              rd_idx,
  input  logic [tag_w-1:0]              rd_tag,
  input  logic                          wr_en,
  input  logic [idx_w-1:0]              wr_idx,
  input  logic [tag_w-1:0]              wr_tag,
  input  logic [frontend_pkg::xlen-1:0] wr_data,
  output logic [frontend_pkg::xlen-1:0] line_data,
  output logic                          line_valid
);

  logic [frontend_pkg::xlen-1:0] data_q [num_lines];
  logic [tag_w-1:0]              tag_q  [num_lines];
  logic [num_lines-1:0]          valid_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_q[wr_idx] <= wr_data;
      tag_q[wr_idx]  <= wr_tag;
    end
  end

  // Combinational read
  assign line_data  = data_q[rd_idx];
  assign line_valid = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

endmodule

// File: run.sh
#!/bin/sh
# Builds the front end testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module frontend_tb \
  -o frontend_sim > sim.log 2>&1 \
  && ./obj_dir/frontend_sim >> sim.log 2>&1 \
  || echo "build or simulation ended with an error, see sim.log"
grep -q "Everything OK" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL, see sim.log"; exit 1; }

// File: tb.f
hw/frontend_pkg.sv
hw/icache_mem.sv
hw/icache_ctrl.sv
hw/fetch_stage.sv
hw/fetch_buffer.sv
hw/dispatch_stage.sv
hw/frontend.sv
bench/frontend_model.sv
bench/frontend_tb.sv
